// File: include/pdp8_acc_defs.svh
/* width, step count and EAE opcode macros for the accumulator unit */
`ifndef PDP8_ACC_DEFS_SVH
`define PDP8_ACC_DEFS_SVH

// data path
`define PDP8_WORD_W 12

// EAE step counter, wide enough for the longest loop
`define PDP8_SC_W 5

// iterations per EAE instruction
`define PDP8_MUL_STEPS 12
`define PDP8_DIV_STEPS 12

// EAE mode A instruction codes, matched exactly
`define PDP8_OP_MUL 12'o7405
`define PDP8_OP_DIV 12'o7407

`endif

// File: pdp8_acc.f
+incdir+include
source/pdp8_acc_pkg.sv
source/acc_decode.sv
source/acc_sequencer.sv
source/acc_operate.sv
source/eae_muldiv.sv
source/acc_registers.sv
source/pdp8_acc_unit.sv
tests/tb_pdp8_acc_unit.sv

// File: source/acc_decode.sv
/* instruction decode for the accumulator unit
   opcode class, rotate kind and microinstruction flags */
`include "pdp8_acc_defs.svh"

module acc_decode
    import pdp8_acc_pkg::*;
(
    input  word_t instruction,
    output op_t   op,
    output rot_t  rot,
    output logic  cla,
    output logic  cll,
    output logic  cma,
    output logic  cml,
    output logic  iac,
    output logic  mqa,
    output logic  mql
);

    always_comb
    begin
        op  = OP_NOP;
        rot = ROT_NONE;
        cla = 1'b0;
        cll = 1'b0;
        cma = 1'b0;
        cml = 1'b0;
        iac = 1'b0;
        mqa = 1'b0;
        mql = 1'b0;
        if (instruction == `PDP8_OP_MUL)
            op = OP_MUL;
        else if (instruction == `PDP8_OP_DIV)
            op = OP_DIV;
        else
        begin
            case (instruction[0:2])
                3'o0: op = OP_AND;
                3'o1: op = OP_TAD;
                3'o3: op = OP_DCA;
                3'o7:
                begin
                    if (!instruction[3])  // group 1
                    begin
                        op  = OP_GRP1;
                        cla = instruction[4];
                        cll = instruction[5];
                        cma = instruction[6];
                        cml = instruction[7];
                        iac = instruction[11];
                        case (instruction[8:10])
                            3'b001: rot = ROT_BSW;
                            3'b010: rot = ROT_RAL;
                            3'b011: rot = ROT_RTL;
                            3'b100: rot = ROT_RAR;
                            3'b101: rot = ROT_RTR;
                            default: rot = ROT_NONE;  // both directions at once
                        endcase
                    end
                    else if (instruction[11])  // group 3, group 2 falls through
                    begin
                        op  = OP_MQ;
                        cla = instruction[4];
                        mqa = instruction[5];
                        mql = instruction[7];
                    end
                end
                default: op = OP_NOP;  // isz, jms, jmp, iot
            endcase
        end
    end

endmodule

// File: source/acc_operate.sv
/* next ac, link and mq for the non-EAE operations
   memory reference, group 1 and group 3 mode A, one phase at a time */
module acc_operate
    import pdp8_acc_pkg::*;
(
    input  phase_t phase,
    input  op_t    op,
    input  rot_t   rot,
    input  logic   cla,
    input  logic   cll,
    input  logic   cma,
    input  logic   cml,
    input  logic   iac,
    input  logic   mqa,
    input  logic   mql,
    input  word_t  operand,
    input  word_t  ac,
    input  word_t  mq,
    input  logic   link,
    output word_t  ac_next,
    output word_t  mq_next,
    output logic   link_next
);

    logic [0:12] lac;      // link:ac as one 13 bit value
    logic [0:12] tad_sum;  // carry out in bit 0
    word_t       ac_clr;
    logic        link_clr;

    assign lac      = {link, ac};
    assign tad_sum  = {1'b0, ac} + {1'b0, operand};
    assign ac_clr   = cla ? '0 : ac;
    assign link_clr = cll ? 1'b0 : link;

    always_comb
    begin
        ac_next   = ac;
        mq_next   = mq;
        link_next = link;
        case (phase)
            PH_1:
            begin
                case (op)
                    OP_AND: ac_next = ac & operand;
                    OP_TAD:
                    begin
                        ac_next   = tad_sum[1:12];
                        link_next = link ^ tad_sum[0];  // carry complements link
                    end
                    OP_DCA: ac_next = '0;
                    OP_GRP1:
                    begin
                        ac_next   = cma ? ~ac_clr : ac_clr;
                        link_next = link_clr ^ cml;
                    end
                    OP_MQ:
                    begin
                        // cla first, then mqa ors mq in and mql moves ac out
                        ac_next = (mqa ? mq : '0) | (mql ? '0 : ac_clr);
                        mq_next = mql ? ac_clr : mq;
                    end
                    default: ;
                endcase
            end
            PH_2:
            begin
                if ((op == OP_GRP1) && iac)
                    {link_next, ac_next} = lac + 13'd1;
            end
            PH_3:
            begin
                if (op == OP_GRP1)
                begin
                    case (rot)
                        ROT_RAL: {link_next, ac_next} = {lac[1:12], lac[0]};
                        ROT_RTL: {link_next, ac_next} = {lac[2:12], lac[0:1]};
                        ROT_RAR: {link_next, ac_next} = {lac[12], lac[0:11]};
                        ROT_RTR: {link_next, ac_next} = {lac[11:12], lac[0:10]};
                        ROT_BSW: ac_next = {ac[6:11], ac[0:5]};  // link untouched
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase
    end

endmodule

// File: source/acc_registers.sv
/* architectural AC, LINK and MQ registers
   load from the operate or the EAE path depending on phase */
module acc_registers
    import pdp8_acc_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  phase_t phase,
    input  word_t  op_ac_next,
    input  word_t  op_mq_next,
    input  word_t  eae_ac_next,
    input  word_t  eae_mq_next,
    input  logic   op_link_next,
    input  logic   eae_link_next,
    output word_t  ac,
    output word_t  mq,
    output logic   link
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ac   <= '0;
            mq   <= '0;
            link <= 1'b0;
        end
        else
        begin
            case (phase)
                PH_1,
                PH_2,
                PH_3:
                begin
                    ac   <= op_ac_next;
                    mq   <= op_mq_next;
                    link <= op_link_next;
                end
                PH_EAE_SETUP,
                PH_EAE_STEP:
                begin
                    ac   <= eae_ac_next;
                    mq   <= eae_mq_next;
                    link <= eae_link_next;
                end
                default: ;  // idle and done hold the result
            endcase
        end
    end

endmodule

// File: source/acc_sequencer.sv
/* phase sequencer for the accumulator unit
   captures the instruction, steps the phases, drives busy and done */
module acc_sequencer
    import pdp8_acc_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  word_t  instruction_in,
    input  word_t  operand_in,
    input  op_t    op,
    input  logic   eae_last,
    output word_t  instruction,
    output word_t  operand,
    output phase_t phase,
    output logic   busy,
    output logic   done
);

    phase_t state;
    logic   eae_op;
    logic   accept;

    assign eae_op = (op == OP_MUL) || (op == OP_DIV);
    assign accept = start && (state == PH_IDLE) && !busy;

    // first phase becomes the EAE setup once the captured word decodes
    assign phase = ((state == PH_1) && eae_op) ? PH_EAE_SETUP : state;

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            instruction <= instruction_in;
            operand     <= operand_in;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= PH_IDLE;
            busy  <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            busy <= (phase != PH_IDLE);  // lags the phase by one cycle
            done <= (phase == PH_DONE);
            case (phase)
                PH_IDLE:
                begin
                    if (accept)
                        state <= PH_1;
                end
                PH_1: state <= PH_2;
                PH_2: state <= PH_3;
                PH_3: state <= PH_DONE;
                PH_EAE_SETUP,
                PH_EAE_STEP:
                begin
                    if (eae_last)
                        state <= PH_DONE;  // div overflow ends in setup
                    else
                        state <= PH_EAE_STEP;
                end
                default: state <= PH_IDLE;
            endcase
        end
    end

endmodule

// File: source/eae_muldiv.sv
/* EAE multiply and divide
   step counter plus one shift-add or restoring subtract per step */
`include "pdp8_acc_defs.svh"

module eae_muldiv
    import pdp8_acc_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  phase_t phase,
    input  op_t    op,
    input  word_t  operand,
    input  word_t  ac,
    input  word_t  mq,
    output word_t  ac_next,
    output word_t  mq_next,
    output logic   link_next,
    output logic   eae_last
);

    logic [`PDP8_SC_W-1:0] sc;
    logic [0:12]           mul_sum;   // carry out in bit 0
    logic [0:12]           div_rem;   // partial remainder shifted left
    logic [0:12]           div_diff;
    logic                  div_fits;
    logic                  div_ovf;

    assign mul_sum  = {1'b0, ac} + {1'b0, operand};
    assign div_rem  = {ac, mq[0]};
    assign div_diff = div_rem - {1'b0, operand};
    assign div_fits = div_rem >= {1'b0, operand};
    assign div_ovf  = ac >= operand;  // quotient would not fit in 12 bits

    always_comb
    begin
        ac_next   = ac;
        mq_next   = mq;
        link_next = 1'b0;  // mul and a clean div leave link clear
        eae_last  = 1'b0;
        case (phase)
            PH_EAE_SETUP:
            begin
                if ((op == OP_DIV) && div_ovf)
                begin
                    link_next = 1'b1;
                    mq_next   = {mq[1:11], 1'b1};
                    eae_last  = 1'b1;
                end
            end
            PH_EAE_STEP:
            begin
                eae_last = (sc == `PDP8_SC_W'(1));
                if (op == OP_MUL)
                begin
                    if (mq[11])  // add then shift ac:mq right
                        {ac_next, mq_next} = {mul_sum, mq[0:10]};
                    else
                        {ac_next, mq_next} = {1'b0, ac, mq[0:10]};
                end
                else if (div_fits)
                begin
                    ac_next = div_diff[1:12];
                    mq_next = {mq[1:11], 1'b1};
                end
                else
                begin
                    ac_next = div_rem[1:12];  // restore, keep the shift
                    mq_next = {mq[1:11], 1'b0};
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            sc <= '0;
        else if (phase == PH_EAE_SETUP)
            sc <= (op == OP_MUL) ? `PDP8_SC_W'(`PDP8_MUL_STEPS)
                                 : `PDP8_SC_W'(`PDP8_DIV_STEPS);
        else if (phase == PH_EAE_STEP)
            sc <= sc - `PDP8_SC_W'(1);
    end

endmodule

// File: source/pdp8_acc_pkg.sv
/* shared types of the accumulator unit
   data word, opcode class, rotate kind and sequencer phase */
`include "pdp8_acc_defs.svh"

package pdp8_acc_pkg;

    typedef logic [0:`PDP8_WORD_W-1] word_t;  // bit 0 is the msb, pdp-8 order

    typedef enum logic [2:0] {
        OP_NOP,   // anything the unit does not handle
        OP_AND,
        OP_TAD,
        OP_DCA,
        OP_GRP1,  // group 1 operate
        OP_MQ,    // group 3, mode A mq microinstructions
        OP_MUL,
        OP_DIV
    } op_t;

    typedef enum logic [2:0] {
        ROT_NONE,
        ROT_RAL,
        ROT_RTL,
        ROT_RAR,
        ROT_RTR,
        ROT_BSW
    } rot_t;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_1,
        PH_2,
        PH_3,
        PH_EAE_SETUP,
        PH_EAE_STEP,
        PH_DONE
    } phase_t;

endpackage

// File: source/pdp8_acc_unit.sv
/* top level of the PDP-8/e accumulator unit */
module pdp8_acc_unit
    import pdp8_acc_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  word_t instruction,
    input  word_t operand,
    output word_t ac,
    output logic  link,
    output word_t mq,
    output logic  busy,
    output logic  done
);

    word_t  instr_q;     // captured instruction
    word_t  operand_q;   // captured memory operand
    op_t    op;
    rot_t   rot;
    phase_t phase;
    logic   cla;
    logic   cll;
    logic   cma;
    logic   cml;
    logic   iac;
    logic   mqa;
    logic   mql;
    logic   eae_last;
    word_t  op_ac_next;
    word_t  op_mq_next;
    logic   op_link_next;
    word_t  eae_ac_next;
    word_t  eae_mq_next;
    logic   eae_link_next;

    acc_decode acc_decode_inst (
        .instruction(instr_q),
        .op(op),
        .rot(rot),
        .cla(cla),
        .cll(cll),
        .cma(cma),
        .cml(cml),
        .iac(iac),
        .mqa(mqa),
        .mql(mql)
    );

    acc_sequencer acc_sequencer_inst (
        .clk(clk),
        .reset(reset),
        .start(start),
        .instruction_in(instruction),
        .operand_in(operand),
        .op(op),
        .eae_last(eae_last),
        .instruction(instr_q),
        .operand(operand_q),
        .phase(phase),
        .busy(busy),
        .done(done)
    );

    acc_operate acc_operate_inst (
        .phase(phase),
        .op(op),
        .rot(rot),
        .cla(cla),
        .cll(cll),
        .cma(cma),
        .cml(cml),
        .iac(iac),
        .mqa(mqa),
        .mql(mql),
        .operand(operand_q),
        .ac(ac),
        .mq(mq),
        .link(link),
        .ac_next(op_ac_next),
        .mq_next(op_mq_next),
        .link_next(op_link_next)
    );

    eae_muldiv eae_muldiv_inst (
        .clk(clk),
        .reset(reset),
        .phase(phase),
        .op(op),
        .operand(operand_q),
        .ac(ac),
        .mq(mq),
        .ac_next(eae_ac_next),
        .mq_next(eae_mq_next),
        .link_next(eae_link_next),
        .eae_last(eae_last)
    );

    acc_registers acc_registers_inst (
        .clk(clk),
        .reset(reset),
        .phase(phase),
        .op_ac_next(op_ac_next),
        .op_mq_next(op_mq_next),
        .eae_ac_next(eae_ac_next),
        .eae_mq_next(eae_mq_next),
        .op_link_next(op_link_next),
        .eae_link_next(eae_link_next),
        .ac(ac),
        .mq(mq),
        .link(link)
    );

endmodule

// File: tests/tb_pdp8_acc_unit.sv
/* testbench for the accumulator unit
   random stimulus, reference model, assertion checks and reporting */
`include "pdp8_acc_defs.svh"

module tb_pdp8_acc_unit;

    localparam int CYCLE_LIMIT = 4000;  // tests need about 2500 cycles
    localparam int DONE_LIMIT  = 40;    // longest op is EAE at about 15 cycles

    logic        clk;
    logic        reset;
    logic        start;
    logic [11:0] instruction;
    logic [11:0] operand;
    logic [11:0] ac;
    logic        link;
    logic [11:0] mq;
    logic        busy;
    logic        done;

    logic [11:0] m_ac;  // reference model registers
    logic        m_link;
    logic [11:0] m_mq;
    logic        done_q;
    integer      seed;
    int          errors;
    int          checks;
    int          cycles;
    int          done_count;

    pdp8_acc_unit pdp8_acc_unit_inst (
        .clk(clk),
        .reset(reset),
        .start(start),
        .instruction(instruction),
        .operand(operand),
        .ac(ac),
        .link(link),
        .mq(mq),
        .busy(busy),
        .done(done)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // handshake rules sampled mid cycle
    always @(negedge clk)
    begin
        if (reset)
            done_q <= 1'b0;
        else
        begin
            if (done_q)
                assert (!busy) else
                begin
                    $display("FAIL t=%0t: busy still high one cycle after done", $time);
                    errors++;
                end
            assert (!done || busy) else
            begin
                $display("FAIL t=%0t: done high while busy is low", $time);
                errors++;
            end
            if (done)
                done_count++;
            done_q <= done;
        end
    end

    task automatic check_eq(input string what, input logic [12:0] got, input logic [12:0] exp);
        checks++;
        assert (got === exp) else
        begin
            $display("FAIL t=%0t: %s is %05o, model says %05o", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_regs(input logic [11:0] instr);
        check_eq($sformatf("ac after %04o", instr), ac, m_ac);
        check_eq($sformatf("link after %04o", instr), link, m_link);
        check_eq($sformatf("mq after %04o", instr), mq, m_mq);
    endtask

    // clear, complement, increment, then rotate
    task automatic model_group1(input logic [11:0] instr);
        logic [12:0] lac;
        if (instr[7])
            m_ac = '0;
        if (instr[6])
            m_link = 1'b0;
        if (instr[5])
            m_ac = ~m_ac;
        if (instr[4])
            m_link = ~m_link;
        if (instr[0])
            {m_link, m_ac} = {m_link, m_ac} + 13'd1;
        lac = {m_link, m_ac};
        if (instr[2] && !instr[3])  // left rotate by one or by two with bit 0002
            lac = instr[1] ? {lac[10:0], lac[12:11]} : {lac[11:0], lac[12]};
        else if (instr[3] && !instr[2])
            lac = instr[1] ? {lac[1:0], lac[12:2]} : {lac[0], lac[12:1]};
        else if (instr[1] && !instr[3] && !instr[2])
            lac[11:0] = {lac[5:0], lac[11:6]};  // byte swap
        {m_link, m_ac} = lac;
    endtask

    task automatic model_mq(input logic [11:0] instr);
        logic [11:0] ac_c;
        logic [11:0] new_ac;
        ac_c = instr[7] ? 12'o0000 : m_ac;
        if (instr[4])  // mql moves ac to mq and swaps when mqa is set
        begin
            new_ac = instr[6] ? m_mq : 12'o0000;
            m_mq   = ac_c;
            m_ac   = new_ac;
        end
        else
            m_ac = ac_c | (instr[6] ? m_mq : 12'o0000);
    endtask

    task automatic model_step(input logic [11:0] instr, input logic [11:0] opnd);
        logic [12:0] sum;
        logic [23:0] wide;
        if (instr == `PDP8_OP_MUL)
        begin
            wide = m_mq * opnd + m_ac;
            {m_ac, m_mq} = wide;
            m_link = 1'b0;
        end
        else if (instr == `PDP8_OP_DIV && m_ac >= opnd)
        begin
            m_link = 1'b1;  // overflow keeps ac
            m_mq   = {m_mq[10:0], 1'b1};
        end
        else if (instr == `PDP8_OP_DIV)
        begin
            wide   = {m_ac, m_mq};
            m_mq   = wide / opnd;
            m_ac   = wide % opnd;
            m_link = 1'b0;
        end
        else
        begin
            case (instr[11:9])
                3'o0: m_ac = m_ac & opnd;
                3'o1:
                begin
                    sum    = m_ac + opnd;
                    m_ac   = sum[11:0];
                    m_link = m_link ^ sum[12];
                end
                3'o3: m_ac = '0;
                3'o7:
                begin
                    if (!instr[8])
                        model_group1(instr);
                    else if (instr[0])
                        model_mq(instr);
                end
                default: ;
            endcase
        end
    endtask

    // entered and left on a falling edge; hammer keeps start high while busy
    task automatic run_op(input logic [11:0] instr, input logic [11:0] opnd,
                          input bit hammer, output int lat);
        instruction = instr;
        operand     = opnd;
        start       = 1'b1;
        @(negedge clk);
        start = 1'b0;
        lat   = 0;
        while (!done && lat < DONE_LIMIT)
        begin
            @(negedge clk);
            lat++;
            check_eq($sformatf("busy during %04o", instr), busy, 1);
            if (hammer)
            begin
                start       = 1'b1;
                instruction = 12'o7200;
            end
        end
        if (!done)
        begin
            $display("no done pulse within %0d cycles for instruction %04o", DONE_LIMIT, instr);
            errors++;
        end
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic exec(input logic [11:0] instr, input logic [11:0] opnd);
        int lat;
        run_op(instr, opnd, 1'b0, lat);
        model_step(instr, opnd);
        check_regs(instr);
        if (instr != `PDP8_OP_MUL && instr != `PDP8_OP_DIV)
            check_eq($sformatf("done latency of %04o", instr), lat, 4);
    endtask

    // cla cll, tad, mql, tad, then cml if needed
    task automatic set_regs(input logic [11:0] ac_v, input logic [11:0] mq_v, input bit link_v);
        exec(12'o7300, 12'o0000);
        exec(12'o1000, mq_v);
        exec(12'o7421, 12'o0000);
        exec(12'o1000, ac_v);
        if (link_v)
            exec(12'o7020, 12'o0000);
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s finished, %0d errors so far", num, name, errors);
    endtask

    logic [11:0] mq_ops [7] = '{12'o7501, 12'o7421, 12'o7521, 12'o7601,
                                12'o7621, 12'o7701, 12'o7721};

    initial
    begin
        logic [11:0] r12;
        logic [11:0] opnd;
        logic [2:0]  cls;
        int          count0;
        int          lat;
        seed        = 85;
        cycles      = 0;
        reset       = 1'b1;
        start       = 1'b0;
        instruction = 12'o0000;
        operand     = 12'o0000;
        m_ac        = '0;
        m_link      = 1'b0;
        m_mq        = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_regs(12'o0000);
        check_eq("busy after reset", busy, 0);
        check_eq("done after reset", done, 0);
        report_test(1, "reset state");

        repeat (20)
        begin
            set_regs($random(seed), $random(seed), $random(seed) & 1);
            exec(12'o7000 | ($random(seed) & 12'o0377), 12'o0000);
        end
        report_test(2, "group 1 operate");

        repeat (20)
        begin
            set_regs($random(seed), $random(seed), $random(seed) & 1);
            r12 = $random(seed);
            cls = (r12 % 3 == 2) ? 3'o3 : 3'(r12 % 3);  // and, tad, dca
            exec({cls, 9'($random(seed))}, $random(seed));
        end
        report_test(3, "memory reference");

        foreach (mq_ops[i])
        begin
            set_regs($random(seed), $random(seed), $random(seed) & 1);
            exec(mq_ops[i], 12'o0000);
        end
        report_test(4, "mq microinstructions");

        repeat (6)
        begin
            set_regs($random(seed), $random(seed), 1'b1);
            exec(`PDP8_OP_MUL, $random(seed));
        end
        repeat (6)
        begin
            opnd = $random(seed);
            if (opnd == 12'o0000)
                opnd = 12'o0001;
            r12 = $random(seed);
            set_regs(r12 % opnd, $random(seed), 1'b1);  // ac below divisor
            exec(`PDP8_OP_DIV, opnd);
        end
        repeat (3)
        begin
            set_regs($random(seed) | 12'o4000, $random(seed), 1'b0);
            exec(`PDP8_OP_DIV, $random(seed) & 12'o0777);
        end
        report_test(5, "eae multiply and divide");

        set_regs($random(seed), $random(seed), 1'b0);
        count0 = done_count;
        opnd   = $random(seed);
        run_op(`PDP8_OP_MUL, opnd, 1'b1, lat);
        model_step(`PDP8_OP_MUL, opnd);
        repeat (20) @(negedge clk);
        check_regs(`PDP8_OP_MUL);
        check_eq("done pulses for one accepted start", done_count - count0, 1);
        report_test(6, "start while busy");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
